// ==== rtl/dma_bus_pkg.sv ====
//****************************************
// dma bus definitions
// engine bus word, control bit positions,
// request descriptor and sequencer phases
//****************************************

package dma_bus_pkg;

  localparam int DMA_DATA_W = 64;
  localparam int DMA_CTRL_W = 8;

  // one word on tohost or fromhost
  typedef struct packed {
    logic [DMA_DATA_W-1:0] data;
    logic [DMA_CTRL_W-1:0] ctrl;
  } dma_beat_t;

  // control bit positions
  localparam int CTRL_ACK_TAG  = 0;  // first ack word
  localparam int CTRL_LO_VALID = 2;
  localparam int CTRL_HI_VALID = 3;  // request end on tohost
  localparam int CTRL_REQ      = 4;
  localparam int CTRL_ACK_LEN  = 5;  // second ack word

  localparam logic [DMA_CTRL_W-1:0] CTRL_DATA =
    DMA_CTRL_W'((1 << CTRL_LO_VALID) | (1 << CTRL_HI_VALID));  // 8'h0C
  localparam logic [DMA_CTRL_W-1:0] CTRL_END_HALF =
    DMA_CTRL_W'((1 << CTRL_LO_VALID) | (1 << CTRL_REQ));  // 8'h14
  localparam logic [DMA_CTRL_W-1:0] CTRL_END_FULL =
    DMA_CTRL_W'((1 << CTRL_LO_VALID) | (1 << CTRL_HI_VALID) | (1 << CTRL_REQ));  // 8'h1C

  typedef struct packed {
    logic [3:0]  tag;     // request data 39..36
    logic [15:0] length;  // request data 15..0
  } dma_desc_t;

  localparam int REQ_QUEUE_DEPTH = 4;
  localparam int REQ_PTR_W       = $clog2(REQ_QUEUE_DEPTH);
  localparam int REQ_CNT_W       = $clog2(REQ_QUEUE_DEPTH + 1);

  typedef enum logic [1:0] {IDLE, ACK_TAG, ACK_LEN, DATA} down_phase_t;

endpackage

// ==== rtl/axis_pkg.sv ====
//****************************************
// axi-stream definitions
// payload beat as carried on the
// stream side of the bridge
//****************************************

package axis_pkg;

  localparam int AXIS_DATA_W = 64;
  localparam int AXIS_KEEP_W = AXIS_DATA_W / 8;

  // valid and ready travel separately
  typedef struct packed {
    logic [AXIS_DATA_W-1:0] tdata;
    logic [AXIS_KEEP_W-1:0] tkeep;
    logic                   tlast;  // transfer end
  } axis_beat_t;

endpackage

// ==== rtl/dma_req_queue.sv ====
//****************************************
// dma request queue
// catches first request words on tohost
// and keeps their descriptors in order
//****************************************
`timescale 1ns/1ps

module dma_req_queue
  import dma_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  dma_beat_t req_beat,
  input  logic      req_valid,
  input  logic      req_pop,
  output dma_desc_t head,
  output logic      req_empty,
  output logic      req_almost_full
);

  dma_desc_t            mem [REQ_QUEUE_DEPTH];
  logic [REQ_PTR_W-1:0] wr_ptr;
  logic [REQ_PTR_W-1:0] rd_ptr;
  logic [REQ_CNT_W-1:0] count;
  logic                 first_word;
  logic                 push;
  logic                 pop;

  // first word of a request, second word has hi valid set
  assign first_word = req_valid && req_beat.ctrl[CTRL_REQ] && !req_beat.ctrl[CTRL_HI_VALID];
  assign push       = first_word && (count != REQ_CNT_W'(REQ_QUEUE_DEPTH));  // full drops it
  assign pop        = req_pop && !req_empty;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr].tag    <= req_beat.data[39:36];
      mem[wr_ptr].length <= req_beat.data[15:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head            = mem[rd_ptr];
  assign req_empty       = (count == '0);
  assign req_almost_full = (count >= REQ_CNT_W'(REQ_QUEUE_DEPTH - 1));

endmodule

// ==== rtl/dma_down_fsm.sv ====
//****************************************
// downstream sequencer
// pops one descriptor at a time and steps
// through tag ack, length ack and data
//****************************************
`timescale 1ns/1ps

module dma_down_fsm
  import dma_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  dma_desc_t   head,
  input  logic        req_empty,
  input  logic        resp_accept,
  input  logic        data_done,
  output logic        req_pop,
  output down_phase_t phase,
  output dma_desc_t   desc
);

  down_phase_t phase_nxt;

  // only start a new request from idle
  assign req_pop = (phase == IDLE) && !req_empty;

  //****************************************
  // next phase
  //****************************************
  always_comb
  begin
    phase_nxt = phase;
    case (phase)
      IDLE:
      begin
        if (req_pop)
          phase_nxt = ACK_TAG;
      end
      ACK_TAG:
      begin
        // ack word is always valid here
        if (resp_accept)
          phase_nxt = ACK_LEN;
      end
      ACK_LEN:
      begin
        if (resp_accept)
          phase_nxt = DATA;
      end
      DATA:
      begin
        if (data_done)  // tlast beat went out
          phase_nxt = IDLE;
      end
      default:
      begin
        phase_nxt = IDLE;
      end
    endcase
  end

  //****************************************
  // phase and descriptor registers
  //****************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      phase <= IDLE;
    else
      phase <= phase_nxt;
  end

  // held for the whole transfer
  always_ff @(posedge clk)
  begin
    if (req_pop)
      desc <= head;
  end

endmodule

// ==== rtl/dma_resp_mux.sv ====
//****************************************
// fromhost response mux
// forms ack words and forwards stream
// beats with data or end control codes
//****************************************
`timescale 1ns/1ps

module dma_resp_mux
  import dma_bus_pkg::*;
  import axis_pkg::*;
(
  input  down_phase_t phase,
  input  dma_desc_t   desc,
  input  axis_beat_t  s_axis,
  input  logic        s_axis_tvalid,
  input  logic        resp_accept,
  output dma_beat_t   resp_beat,
  output logic        resp_valid,
  output logic        s_axis_tready,
  output logic        data_done
);

  logic [DMA_CTRL_W-1:0] end_code;

  // upper half of keep empty means only the low word is valid
  assign end_code = (s_axis.tkeep[AXIS_KEEP_W-1:AXIS_KEEP_W/2] == '0) ? CTRL_END_HALF
                                                                       : CTRL_END_FULL;

  always_comb
  begin
    resp_beat     = '0;
    resp_valid    = 1'b0;
    s_axis_tready = 1'b0;
    case (phase)
      ACK_TAG:
      begin
        resp_beat.data[7:4]           = desc.tag;
        resp_beat.ctrl[CTRL_ACK_TAG]  = 1'b1;
        resp_valid                    = 1'b1;
      end
      ACK_LEN:
      begin
        resp_beat.data[15:0]          = desc.length;
        resp_beat.ctrl[CTRL_ACK_LEN]  = 1'b1;
        resp_valid                    = 1'b1;
      end
      DATA:
      begin
        resp_beat.data = s_axis.tdata;
        resp_beat.ctrl = s_axis.tlast ? end_code : CTRL_DATA;
        resp_valid     = s_axis_tvalid;
        s_axis_tready  = resp_accept;  // stream stalls with the engine
      end
      default:
      begin
        resp_valid = 1'b0;
      end
    endcase
  end

  assign data_done = (phase == DATA) && s_axis_tvalid && s_axis_tready && s_axis.tlast;

endmodule

// ==== rtl/dma_axis_bridge.sv ====
//****************************************
// dma engine to axi-stream bridge
// downstream path: request queue,
// sequencer and fromhost response mux
//****************************************
`timescale 1ns/1ps

module dma_axis_bridge
  import dma_bus_pkg::*;
  import axis_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // tohost requests
  input  dma_beat_t  req_beat,
  input  logic       req_valid,
  output logic       req_almost_full,
  // fromhost responses
  output dma_beat_t  resp_beat,
  output logic       resp_valid,
  input  logic       resp_accept,
  // payload stream
  input  axis_beat_t s_axis,
  input  logic       s_axis_tvalid,
  output logic       s_axis_tready
);

  dma_desc_t   head;
  dma_desc_t   desc;
  down_phase_t phase;
  logic        req_empty;
  logic        req_pop;
  logic        data_done;

  dma_req_queue dma_req_queue_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_beat        (req_beat),
    .req_valid       (req_valid),
    .req_pop         (req_pop),
    .head            (head),
    .req_empty       (req_empty),
    .req_almost_full (req_almost_full)
  );

  dma_down_fsm dma_down_fsm_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .head        (head),
    .req_empty   (req_empty),
    .resp_accept (resp_accept),
    .data_done   (data_done),
    .req_pop     (req_pop),
    .phase       (phase),
    .desc        (desc)
  );

  dma_resp_mux dma_resp_mux_i (
    .phase         (phase),
    .desc          (desc),
    .s_axis        (s_axis),
    .s_axis_tvalid (s_axis_tvalid),
    .resp_accept   (resp_accept),
    .resp_beat     (resp_beat),
    .resp_valid    (resp_valid),
    .s_axis_tready (s_axis_tready),
    .data_done     (data_done)
  );

endmodule

// ==== dv/dma_axis_bridge_chk.sv ====
//****************************************
// dma axis bridge protocol checks
// bound into the top level
//****************************************
`timescale 1ns/1ps

module dma_axis_bridge_chk
  import dma_bus_pkg::*;
(
  input logic                 clk,
  input logic                 rst_n,
  input dma_beat_t            req_beat,
  input logic                 req_valid,
  input logic                 req_almost_full,
  input logic [REQ_CNT_W-1:0] q_count,
  input down_phase_t          phase,
  input dma_beat_t            resp_beat,
  input logic                 resp_valid,
  input logic                 resp_accept,
  input logic                 s_axis_tready
);

  logic first_word;

  assign first_word = req_valid && req_beat.ctrl[CTRL_REQ] && !req_beat.ctrl[CTRL_HI_VALID];

  // ack word waits unchanged for accept
  ack_stable_a : assert property (@(posedge clk) disable iff (!rst_n)
    (resp_valid && !resp_accept && (phase == ACK_TAG || phase == ACK_LEN))
      |=> (resp_valid && $stable(resp_beat)))
    else $error("ack word changed before it was accepted");

  ready_a : assert property (@(posedge clk) disable iff (!rst_n)
    s_axis_tready |-> resp_accept)
    else $error("stream ready without engine accept");

  no_overflow_a : assert property (@(posedge clk) disable iff (!rst_n)
    (req_almost_full && q_count == REQ_CNT_W'(REQ_QUEUE_DEPTH)) |-> !first_word)
    else $error("request arrived while the request queue was full");

endmodule

bind dma_axis_bridge dma_axis_bridge_chk dma_axis_bridge_chk_i (
  .clk             (clk),
  .rst_n           (rst_n),
  .req_beat        (req_beat),
  .req_valid       (req_valid),
  .req_almost_full (req_almost_full),
  .q_count         (dma_req_queue_i.count),
  .phase           (dma_down_fsm_i.phase),
  .resp_beat       (resp_beat),
  .resp_valid      (resp_valid),
  .resp_accept     (resp_accept),
  .s_axis_tready   (s_axis_tready)
);

// ==== dv/dma_axis_bridge_tb.sv ====
//****************************************
// dma axis bridge testbench
// transfer table through request, ack
// and payload paths, checked in order
//****************************************
`timescale 1ns/1ps

module dma_axis_bridge_tb
  import dma_bus_pkg::*;
  import axis_pkg::*;
();

  typedef struct packed {
    logic [3:0]  tag;
    logic [15:0] length;
    logic [7:0]  beats;
    logic [7:0]  last_keep;
    logic        stall;  // random accept gaps
    logic        b2b;    // sent without waiting for the previous transfer
  } xfer_t;

  localparam int NUM_XFER = 7;
  localparam int CLK_HALF = 10;

  xfer_t xfers [NUM_XFER] = '{
    '{4'h1, 16'h0010, 8'd1, 8'hFF, 1'b0, 1'b0},
    '{4'h2, 16'h0040, 8'd4, 8'h0F, 1'b0, 1'b0},
    '{4'h3, 16'h0100, 8'd6, 8'hFF, 1'b0, 1'b0},  // keeps the bridge busy
    '{4'h4, 16'h0020, 8'd3, 8'h03, 1'b1, 1'b1},
    '{4'h5, 16'h0030, 8'd2, 8'hF0, 1'b1, 1'b1},
    '{4'h6, 16'h0008, 8'd5, 8'h1F, 1'b1, 1'b1},
    '{4'h9, 16'h1234, 8'd4, 8'h0F, 1'b1, 1'b0}
  };

  logic       clk = 1'b0;
  logic       rst_n;
  dma_beat_t  req_beat;
  logic       req_valid;
  logic       req_almost_full;
  dma_beat_t  resp_beat;
  logic       resp_valid;
  logic       resp_accept;
  axis_beat_t s_axis;
  logic       s_axis_tvalid;
  logic       s_axis_tready;
  dma_beat_t  exp_q [$];     // expected fromhost words
  axis_beat_t stream_q [$];  // payload beats still to send
  int         done;          // finished transfers
  logic       stream_took;
  integer     seed = 32'h1e32d687;

  always #CLK_HALF clk = ~clk;

  dma_axis_bridge dma_axis_bridge_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_beat        (req_beat),
    .req_valid       (req_valid),
    .req_almost_full (req_almost_full),
    .resp_beat       (resp_beat),
    .resp_valid      (resp_valid),
    .resp_accept     (resp_accept),
    .s_axis          (s_axis),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready)
  );

  //****************************************
  // compare helpers and expected words
  //****************************************
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_beat(input dma_beat_t exp, input dma_beat_t act, input string name);
    if (act !== exp)
      abort_run($sformatf("** Error at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_flag(input logic exp, input logic act, input string name);
    if (act !== exp)
      abort_run($sformatf("** Error at %0t: %s expected %b got %b", $time, name, exp, act));
  endtask

  function automatic dma_beat_t ack_word(input logic is_len, input xfer_t x);
    dma_beat_t w;
    w = '0;
    if (is_len)
    begin
      w.data[15:0]          = x.length;
      w.ctrl[CTRL_ACK_LEN]  = 1'b1;
    end
    else
    begin
      w.data[7:4]           = x.tag;
      w.ctrl[CTRL_ACK_TAG]  = 1'b1;
    end
    return w;
  endfunction

  // first request word plus expected acks and payload
  task automatic issue_request(input int i);
    dma_beat_t  w;
    axis_beat_t b;
    int         k;
    w.data          = {$random(seed), $random(seed)};
    w.data[39:36]   = xfers[i].tag;
    w.data[15:0]    = xfers[i].length;
    w.ctrl          = '0;
    w.ctrl[CTRL_REQ]      = 1'b1;
    w.ctrl[CTRL_LO_VALID] = 1'b1;
    exp_q.push_back(ack_word(1'b0, xfers[i]));
    exp_q.push_back(ack_word(1'b1, xfers[i]));
    for (k = 0; k < xfers[i].beats; k++)
    begin
      b.tdata = {$random(seed), $random(seed)};
      b.tlast = (k == xfers[i].beats - 1);
      b.tkeep = b.tlast ? xfers[i].last_keep : 8'hFF;
      stream_q.push_back(b);
      exp_q.push_back({b.tdata, !b.tlast ? CTRL_DATA :
                       (b.tkeep <= 8'h0F) ? CTRL_END_HALF : CTRL_END_FULL});
    end
    req_beat  = w;
    req_valid = 1'b1;
  endtask

  //****************************************
  // drivers and monitor
  //****************************************
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (done < NUM_XFER && xfers[done].stall)
        resp_accept = ($random(seed) & 1) != 0;
      else
        resp_accept = 1'b1;
      if (!(s_axis_tvalid && !stream_took))  // an offered beat is held until taken
      begin
        s_axis_tvalid = (stream_q.size() > 0) && (($random(seed) & 3) != 0);
        if (s_axis_tvalid)
          s_axis = stream_q[0];
      end
    end
  end

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      stream_took = s_axis_tvalid && s_axis_tready;
      if (stream_took)
        void'(stream_q.pop_front());
      // a data word at the head means the bridge is in its data phase
      if (exp_q.size() > 0 && !exp_q[0].ctrl[CTRL_ACK_TAG] && !exp_q[0].ctrl[CTRL_ACK_LEN])
        check_flag(resp_accept, s_axis_tready, "s_axis_tready");
      else
        check_flag(1'b0, s_axis_tready, "s_axis_tready");
      if (resp_valid && resp_accept)
      begin
        if (exp_q.size() == 0)
          abort_run("the bridge sent a response word that no request asked for");
        check_beat(exp_q[0], resp_beat, "resp_beat");
        if (exp_q[0].ctrl == CTRL_END_HALF || exp_q[0].ctrl == CTRL_END_FULL)
          done = done + 1;
        void'(exp_q.pop_front());
      end
    end
  end

  //****************************************
  // main sequence
  //****************************************
  initial
  begin
    int i;
    rst_n         = 1'b0;
    req_beat      = '0;
    req_valid     = 1'b0;
    resp_accept   = 1'b0;
    s_axis        = '0;
    s_axis_tvalid = 1'b0;
    stream_took   = 1'b0;
    done          = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_flag(1'b0, resp_valid, "resp_valid");
    check_flag(1'b0, s_axis_tready, "s_axis_tready");
    check_flag(1'b0, req_almost_full, "req_almost_full");
    for (i = 0; i < NUM_XFER; i++)
    begin
      if (!xfers[i].b2b)
      begin
        wait (done == i);  // idle bridge, so the ack latency is fixed
        @(negedge clk);
        issue_request(i);
        @(negedge clk);
        req_beat.data = {$random(seed), $random(seed)};
        req_beat.ctrl[CTRL_HI_VALID] = 1'b1;  // second word, must be ignored
        check_flag(1'b0, resp_valid, "resp_valid");
        @(negedge clk);
        req_valid = 1'b0;
        check_flag(1'b1, resp_valid, "resp_valid");
        check_beat(ack_word(1'b0, xfers[i]), resp_beat, "resp_beat");
      end
      else
      begin
        @(negedge clk);
        issue_request(i);
        if (i + 1 == NUM_XFER || !xfers[i + 1].b2b)
        begin
          @(negedge clk);
          req_valid = 1'b0;
          check_flag(1'b1, req_almost_full, "req_almost_full");  // three queued
        end
      end
    end
    wait (done == NUM_XFER);
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0 || stream_q.size() != 0)
      abort_run("payload beats or response words were left over at the end");
    else
    begin
      check_flag(1'b0, resp_valid, "resp_valid");
      check_flag(1'b0, req_almost_full, "req_almost_full");
      $display("Test OK");
      $finish;
    end
  end

  // watchdog, 40 cycles per payload beat plus margin
  initial
  begin
    int total;
    int n;
    total = 0;
    for (n = 0; n < NUM_XFER; n++)
      total = total + xfers[n].beats;
    #((total * 40 + 200) * 2 * CLK_HALF);
    $display("timeout, the bridge stopped moving words before all transfers finished");
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== dma_axis_bridge.f ====
rtl/dma_bus_pkg.sv
rtl/axis_pkg.sv
rtl/dma_req_queue.sv
rtl/dma_down_fsm.sv
rtl/dma_resp_mux.sv
rtl/dma_axis_bridge.sv
dv/dma_axis_bridge_chk.sv
dv/dma_axis_bridge_tb.sv
